// File: build.f
+incdir+common
common/engine_pkg.sv
common/lane_if.sv
hw/feeder/tile_feeder.sv
hw/lane/dotp_lane.sv
hw/drain/requant_drain.sv
hw/tile_engine.sv
dv/tile_engine_checker.sv
dv/tb_tile_engine.sv

// File: common/engine_pkg.sv
// ======================================
// Data types and control struct of
// the tile engine
// ======================================

`include "engine_settings.svh"

package engine_pkg;

  typedef logic signed [`ENG_WI-1:0] elem_t;

  // One input tile
  typedef elem_t [`ENG_M-1:0] inp_t;

  // Weights of one channel, and of all channels, for one tile
  typedef elem_t       [`ENG_M-1:0] weight_row_t;
  typedef weight_row_t [`ENG_N-1:0] weight_t;

  typedef logic signed [`ENG_WO-1:0] acc_t;
  typedef acc_t [`ENG_N-1:0] bias_t;

  // Requantized output vector
  typedef elem_t [`ENG_N-1:0] oup_t;

  typedef logic [$clog2(`ENG_MAX_TILES)-1:0] tile_cnt_t;

  typedef logic [7:0] eps_mult_t;
  typedef logic [4:0] right_shift_t;

  typedef struct packed {
    tile_cnt_t    tiles;
    eps_mult_t    eps_mult;
    right_shift_t right_shift;
    elem_t        add;
    logic         relu;
  } ctrl_t;

endpackage

// File: common/engine_settings.svh
// ======================================
// Size macros of the tile engine
// ======================================

`ifndef ENGINE_SETTINGS_SVH
`define ENGINE_SETTINGS_SVH

// Output channels, one lane each
`define ENG_N 4

// Elements per input tile
`define ENG_M 8

// Element and accumulator widths
`define ENG_WI 8
`define ENG_WO 24

// Weight buffer depth in tiles
`define ENG_MAX_TILES 4

`endif

// File: common/lane_if.sv
// ======================================
// Broadcast tile bus, feeder to lanes
// ======================================

`timescale 1ns/1ps

`include "engine_settings.svh"

interface lane_if;
  import engine_pkg::*;

  logic    valid;
  logic    first;
  logic    last;
  inp_t    inp;
  weight_t weights;
  bias_t   bias;

  modport feeder (
    output valid, first, last, inp, weights, bias
  );

  // Lanes and drain only listen
  modport lane (
    input valid, first, last, inp, weights, bias
  );

endinterface

// File: dv/tb_tile_engine.sv
// ========================================
// Tile engine testbench: stimulus,
// reference model and output compare
// ========================================

`timescale 1ns/1ps

`include "engine_settings.svh"

module tb_tile_engine;
  import engine_pkg::*;

  logic    clk_i;
  logic    rst_ni;
  ctrl_t   ctrl_i;
  logic    bias_valid_i;
  bias_t   bias_i;
  logic    weight_valid_i;
  weight_t weight_i;
  logic    inp_valid_i;
  inp_t    inp_i;
  logic    valid_o;
  oup_t    oup_o;
  logic    busy_o;

  logic [31:0] rng_state;
  int          cyc = 0;
  bias_t       bias_mem;
  weight_t     wt_mem [`ENG_MAX_TILES];
  inp_t        inp_mem [`ENG_MAX_TILES];
  oup_t        exp_q [$];
  int          due_q [$];
  logic        busy_exp = 1'b0;
  tile_cnt_t   tile_pos = '0;
  int          pending = 0;

  tile_engine UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .bias_valid_i  (bias_valid_i),
    .bias_i        (bias_i),
    .weight_valid_i(weight_valid_i),
    .weight_i      (weight_i),
    .inp_valid_i   (inp_valid_i),
    .inp_i         (inp_i),
    .valid_o       (valid_o),
    .oup_o         (oup_o),
    .busy_o        (busy_o)
  );

  always #10 clk_i = ~clk_i;

  // Expected busy_o from sampled tiles and outputs
  always @(posedge clk_i) begin : track_busy
    int left;
    cyc <= cyc + 1;
    left = pending - int'(valid_o);
    busy_exp <= inp_valid_i || (busy_exp && !(valid_o && left == 0 && tile_pos == '0));
    if (inp_valid_i) begin
      if (tile_pos == ctrl_i.tiles) begin
        tile_pos <= '0;
        left++;
      end else begin
        tile_pos <= tile_pos + 1'b1;
      end
    end
    pending <= left;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic elem_t rand_elem();
    return elem_t'(next_rand() >> 24);
  endfunction

  function automatic inp_t rand_tile();
    inp_t t;
    for (int i = 0; i < `ENG_M; i++) begin
      t[i] = rand_elem();
    end
    return t;
  endfunction

  // Bias plus tile sums, then scale, floor shift, offset, clip and ReLU
  function automatic oup_t ref_oup(input bias_t b, input weight_t w [`ENG_MAX_TILES],
                                   input inp_t x [`ENG_MAX_TILES], input ctrl_t c);
    oup_t   o;
    longint acc;
    longint v;
    for (int ch = 0; ch < `ENG_N; ch++) begin
      acc = longint'(b[ch]);
      for (int t = 0; t <= int'(c.tiles); t++) begin
        for (int i = 0; i < `ENG_M; i++) begin
          acc += longint'(x[t][i]) * longint'(w[t][ch][i]);
        end
      end
      v = ((acc * longint'(c.eps_mult)) >>> c.right_shift) + longint'($signed(c.add));
      if (v > 127) begin
        v = 127;
      end else if (v < -128) begin
        v = -128;
      end
      if (c.relu && v < 0) begin
        v = 0;
      end
      o[ch] = elem_t'(v);
    end
    return o;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_oup(input oup_t got, input oup_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: oup_o got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o || exp_q.size() != 0) begin
      if (n == 100) begin
        fail_run("timeout: the engine did not return to idle");
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  // New ctrl, bias and weights once the pipeline is empty
  task automatic load_group(input ctrl_t c);
    logic signed [15:0] b;
    wait_idle();
    ctrl_i = c;
    for (int ch = 0; ch < `ENG_N; ch++) begin
      b = 16'(next_rand() >> 16);
      bias_mem[ch] = acc_t'(b);
    end
    bias_valid_i = 1'b1;
    bias_i       = bias_mem;
    @(negedge clk_i);
    bias_valid_i = 1'b0;
    for (int t = 0; t <= int'(c.tiles); t++) begin
      for (int ch = 0; ch < `ENG_N; ch++) begin
        wt_mem[t][ch] = rand_tile();
      end
      weight_valid_i = 1'b1;
      weight_i       = wt_mem[t];
      @(negedge clk_i);
    end
    weight_valid_i = 1'b0;
  endtask

  task automatic run_vectors(input int count, input bit gap);
    for (int v = 0; v < count; v++) begin
      for (int t = 0; t <= int'(ctrl_i.tiles); t++) begin
        inp_mem[t]  = rand_tile();
        inp_valid_i = 1'b1;
        inp_i       = inp_mem[t];
        if (t == int'(ctrl_i.tiles)) begin
          exp_q.push_back(ref_oup(bias_mem, wt_mem, inp_mem, ctrl_i));
          due_q.push_back(cyc + 3);
        end
        @(negedge clk_i);
        if (gap) begin
          inp_valid_i = 1'b0;
          @(negedge clk_i);
        end
      end
    end
    inp_valid_i = 1'b0;
  endtask

  // Outputs in order, each exactly 3 cycles after its last tile
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_flag("busy_o", busy_o, busy_exp);
    end
    if (rst_ni && valid_o) begin
      if (exp_q.size() == 0) begin
        fail_run("valid_o rose with no output vector expected");
      end else if (cyc != due_q[0]) begin
        fail_run($sformatf("error at %0t: valid_o cycle got %0d expected %0d",
                           $time, cyc, due_q[0]));
      end else begin
        check_oup(oup_o, exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end else if (due_q.size() != 0 && cyc > due_q[0]) begin
      fail_run("an expected output vector never appeared");
    end
  end

  initial begin
    ctrl_t c;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    ctrl_i         = '0;
    bias_valid_i   = 1'b0;
    bias_i         = '0;
    weight_valid_i = 1'b0;
    weight_i       = '0;
    inp_valid_i    = 1'b0;
    inp_i          = '0;
    rng_state      = 32'h43255e8c;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // Single tile, identity requant
    c          = '0;
    c.eps_mult = 8'd1;
    load_group(c);
    run_vectors(3, 1'b1);

    // Four tiles, shift keeps sums off the rails
    c.tiles       = 2'd3;
    c.right_shift = 5'd9;
    load_group(c);
    run_vectors(2, 1'b0);

    for (int g = 0; g < 12; g++) begin
      c.tiles       = tile_cnt_t'(next_rand() >> 30);
      c.eps_mult    = 8'(next_rand() >> 24);
      c.right_shift = right_shift_t'(next_rand() >> 27);
      c.add         = rand_elem();
      c.relu        = g[0];
      load_group(c);
      run_vectors(1 + g % 4, g % 3 == 0);
    end

    wait_idle();
    if (UUT.i_checker.fail_count != 0) begin
      fail_run("bound checker reported assertion failures");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: dv/tile_engine_checker.sv
// ========================================
// Bound assertions on top-level strobes
// ========================================

`timescale 1ns/1ps

module tile_engine_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input engine_pkg::ctrl_t ctrl_i,
  input logic              inp_valid_i,
  input logic              valid_o,
  input engine_pkg::oup_t  oup_o,
  input logic              busy_o
);
  import engine_pkg::*;

  tile_cnt_t   tile_q;
  logic        last_strobe;
  int unsigned fail_count = 0;

  // Own count of inner tiles per vector
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q <= '0;
    end else if (inp_valid_i) begin
      tile_q <= (tile_q == ctrl_i.tiles) ? '0 : tile_q + 1'b1;
    end
  end

  assign last_strobe = inp_valid_i && (tile_q == ctrl_i.tiles);

  property last_to_valid;
    @(posedge clk_i) disable iff (!rst_ni) last_strobe |-> ##3 valid_o;
  endproperty

  a_latency: assert property (last_to_valid) else begin
    $error("valid_o did not follow the last input strobe after 3 cycles");
    fail_count++;
  end

  a_reset: assert property (@(posedge clk_i) !rst_ni |-> !busy_o && !valid_o) else begin
    $error("busy_o or valid_o high during reset");
    fail_count++;
  end

  a_idle_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !valid_o |-> oup_o == '0
  ) else begin
    $error("oup_o not zero while valid_o is low");
    fail_count++;
  end

endmodule

bind tile_engine tile_engine_checker i_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ctrl_i     (ctrl_i),
  .inp_valid_i(inp_valid_i),
  .valid_o    (valid_o),
  .oup_o      (oup_o),
  .busy_o     (busy_o)
);

// File: hw/drain/requant_drain.sv
// ======================================
// Requantization, clip, ReLU and busy
// ======================================

`timescale 1ns/1ps

`include "engine_settings.svh"

module requant_drain (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  engine_pkg::ctrl_t ctrl_i,
  lane_if.lane              tile_i,
  input  logic [`ENG_N-1:0] done_i,
  input  engine_pkg::acc_t  result_i [`ENG_N],
  output logic              valid_o,
  output engine_pkg::oup_t  oup_o,
  output logic              busy_o
);
  import engine_pkg::*;

  localparam int PW = `ENG_WO + 9;
  localparam int MaxVal = 2 ** (`ENG_WI - 1) - 1;
  localparam int MinVal = -(2 ** (`ENG_WI - 1));

  oup_t requant;
  logic fire;
  logic valid_q;
  oup_t oup_q;
  logic busy_q;
  logic open_q;

  // All lanes finish together
  assign fire = done_i[0];

  always_comb begin
    logic signed [PW-1:0] scaled;
    logic signed [PW:0]   sum;
    for (int c = 0; c < `ENG_N; c++) begin
      scaled = result_i[c] * $signed({1'b0, ctrl_i.eps_mult});
      sum    = $signed(scaled >>> ctrl_i.right_shift) + $signed(ctrl_i.add);
      if (sum > MaxVal) begin
        requant[c] = elem_t'(MaxVal);
      end else if (sum < MinVal) begin
        requant[c] = elem_t'(MinVal);
      end else begin
        requant[c] = sum[`ENG_WI-1:0];
      end
      if (ctrl_i.relu && requant[c] < 0) begin
        requant[c] = '0;
      end
    end
  end

  // open_q marks a vector whose last tile has not reached the lanes
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      oup_q   <= '0;
      busy_q  <= 1'b0;
      open_q  <= 1'b0;
    end else begin
      valid_q <= fire;
      oup_q   <= fire ? requant : '0;
      if (tile_i.valid) begin
        open_q <= !tile_i.last;
        busy_q <= 1'b1;
      end else if (valid_q && !fire && !open_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign valid_o = valid_q;
  assign oup_o   = oup_q;
  assign busy_o  = busy_q || tile_i.valid;

endmodule

// File: hw/feeder/tile_feeder.sv
// ======================================
// Weight buffer, bias register and tile
// sequencing onto the lane bus
// ======================================

`timescale 1ns/1ps

`include "engine_settings.svh"

module tile_feeder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  engine_pkg::ctrl_t   ctrl_i,
  input  logic                bias_valid_i,
  input  engine_pkg::bias_t   bias_i,
  input  logic                weight_valid_i,
  input  engine_pkg::weight_t weight_i,
  input  logic                inp_valid_i,
  input  engine_pkg::inp_t    inp_i,
  lane_if.feeder              tile_o
);
  import engine_pkg::*;

  weight_t   wbuf_q [`ENG_MAX_TILES];
  bias_t     bias_q;
  tile_cnt_t wr_ptr_q;
  tile_cnt_t rd_ptr_q;

  // Tile pointers wrap after the last inner tile
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (weight_valid_i) begin
        if (wr_ptr_q == ctrl_i.tiles) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (inp_valid_i) begin
        if (rd_ptr_q == ctrl_i.tiles) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (weight_valid_i) begin
      wbuf_q[wr_ptr_q] <= weight_i;
    end
    if (bias_valid_i) begin
      bias_q <= bias_i;
    end
  end

  // Tile strobe and position flags
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_o.valid <= 1'b0;
      tile_o.first <= 1'b0;
      tile_o.last  <= 1'b0;
    end else begin
      tile_o.valid <= inp_valid_i;
      tile_o.first <= inp_valid_i && (rd_ptr_q == '0);
      tile_o.last  <= inp_valid_i && (rd_ptr_q == ctrl_i.tiles);
    end
  end

  always_ff @(posedge clk_i) begin
    if (inp_valid_i) begin
      tile_o.inp     <= inp_i;
      tile_o.weights <= wbuf_q[rd_ptr_q];
    end
  end

  assign tile_o.bias = bias_q;

endmodule

// File: hw/lane/dotp_lane.sv
// ======================================
// One channel's dot product and
// bias-seeded tile accumulator
// ======================================

`timescale 1ns/1ps

`include "engine_settings.svh"

module dotp_lane #(
  parameter int unsigned LANE = 0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  lane_if.lane              tile_i,
  output logic              done_o,
  output engine_pkg::acc_t  result_o
);
  import engine_pkg::*;

  acc_t tile_sum;
  acc_t acc_q;
  logic done_q;

  always_comb begin
    logic signed [2*`ENG_WI-1:0] prod;
    tile_sum = '0;
    for (int i = 0; i < `ENG_M; i++) begin
      prod     = $signed(tile_i.inp[i]) * $signed(tile_i.weights[LANE][i]);
      tile_sum = tile_sum + prod;
    end
  end

  // First tile starts from the channel bias
  always_ff @(posedge clk_i) begin
    if (tile_i.valid) begin
      acc_q <= tile_i.first ? tile_i.bias[LANE] + tile_sum : acc_q + tile_sum;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= tile_i.valid && tile_i.last;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q;

endmodule

// File: hw/tile_engine.sv
// ======================================
// Tile engine top: feeder, lanes, drain
// ======================================

`timescale 1ns/1ps

`include "engine_settings.svh"

module tile_engine (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  engine_pkg::ctrl_t   ctrl_i,
  input  logic                bias_valid_i,
  input  engine_pkg::bias_t   bias_i,
  input  logic                weight_valid_i,
  input  engine_pkg::weight_t weight_i,
  input  logic                inp_valid_i,
  input  engine_pkg::inp_t    inp_i,
  output logic                valid_o,
  output engine_pkg::oup_t    oup_o,
  output logic                busy_o
);
  import engine_pkg::*;

  logic [`ENG_N-1:0] lane_done;
  acc_t              lane_result [`ENG_N];

  lane_if tile_bus ();

  tile_feeder i_feeder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .bias_valid_i  (bias_valid_i),
    .bias_i        (bias_i),
    .weight_valid_i(weight_valid_i),
    .weight_i      (weight_i),
    .inp_valid_i   (inp_valid_i),
    .inp_i         (inp_i),
    .tile_o        (tile_bus.feeder)
  );

  // One lane per output channel
  for (genvar l = 0; l < `ENG_N; l++) begin : gen_lane
    dotp_lane #(
      .LANE(l)
    ) i_lane (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .tile_i  (tile_bus.lane),
      .done_o  (lane_done[l]),
      .result_o(lane_result[l])
    );
  end

  requant_drain i_drain (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ctrl_i  (ctrl_i),
    .tile_i  (tile_bus.lane),
    .done_i  (lane_done),
    .result_i(lane_result),
    .valid_o (valid_o),
    .oup_o   (oup_o),
    .busy_o  (busy_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_tile_engine \
  -Mdir obj_dir -o sim_tile_engine || exit 1
./obj_dir/sim_tile_engine +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
